// ==== common/mem_bus_pkg.sv ====
// Memory bus widths and payload types shared by the port join.
// Imported by the channel interfaces and every RTL module that touches a payload.
package mem_bus_pkg;

    // ----------------------------------------
    // bus widths
    // ----------------------------------------
    localparam int unsigned ADDR_W = 32;
    localparam int unsigned DATA_W = 64;
    localparam int unsigned BE_W   = DATA_W / 8;
    localparam int unsigned ID_W   = 4;

    // id split into class and tag
    localparam int unsigned CLS_W = 2;
    localparam int unsigned TAG_W = ID_W - CLS_W;

    // ----------------------------------------
    // request channel payload
    // ----------------------------------------
    // reads and writes share one channel, we selects the direction
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              we;
        logic [DATA_W-1:0] wdata;
        logic [BE_W-1:0]   be;
        logic [ID_W-1:0]   id;
    } mem_req_t;

    // ----------------------------------------
    // response channel payload
    // ----------------------------------------
    // read data and write acknowledges share one channel
    // rdata is don't care for a write ack
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic [ID_W-1:0]   id;
        logic              err;
    } mem_rsp_t;

    // ----------------------------------------
    // response id views
    // ----------------------------------------
    // upper bits give the requester class, lower bits an
    // outstanding tag inside that class
    typedef struct packed {
        logic [CLS_W-1:0] cls;
        logic [TAG_W-1:0] tag;
    } rsp_id_fields_t;

    // exact ids are matched on raw, the bypass class on fields.cls
    typedef union packed {
        logic [ID_W-1:0] raw;
        rsp_id_fields_t  fields;
    } rsp_id_u;

endpackage

// ==== common/port_map_pkg.sv ====
// Requester numbering of the port join and the response id classes.
// Index order sets the round-robin order after reset.
package port_map_pkg;

    import mem_bus_pkg::*;

    // requesters, dcache has the first turn after reset
    localparam int unsigned NUM_PORTS   = 3;
    localparam int unsigned PORT_DCACHE = 0;
    localparam int unsigned PORT_BYPASS = 1;
    localparam int unsigned PORT_ICACHE = 2;

    typedef logic [1:0] port_idx_t;

    // id classes used by the response router
    localparam logic [ID_W-1:0]  ID_ICACHE  = 4'b0000;
    localparam logic [ID_W-1:0]  ID_DCACHE  = 4'b1111;
    // any tag under this class belongs to the bypass path
    localparam logic [CLS_W-1:0] CLS_BYPASS = 2'b10;

endpackage

// ==== common/mem_req_if.sv ====
// Request channel between a requester and the memory bus.
// Valid/ready handshake, a transfer happens on an edge with both high.
// Valid and payload hold from the rising of valid until the transfer.
interface mem_req_if
    import mem_bus_pkg::*;
();

    logic     valid;
    logic     ready;
    mem_req_t payload;

    // ----------------------------------------
    // modports
    // ----------------------------------------
    // requester side, or the mux output toward the bus
    modport initiator (
        output valid,
        output payload,
        input  ready
    );

    // side that accepts the request
    modport target (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// ==== common/mem_rsp_if.sv ====
// Response channel from the memory bus back toward a requester.
// Same valid/ready transfer rule as the request channel.
interface mem_rsp_if
    import mem_bus_pkg::*;
();

    logic     valid;
    logic     ready;
    mem_rsp_t payload;

    // ----------------------------------------
    // modports
    // ----------------------------------------
    modport source (
        output valid,
        output payload,
        input  ready
    );

    modport sink (
        input  valid,
        input  payload,
        output ready
    );

endinterface

// ==== logic/lockin_rr_arbiter.sv ====
// Round-robin arbiter with lock-in for a valid/ready bus.
// A grant is frozen until accept_i, then the pointer moves past the winner.
// The grant is combinational while unfrozen.
module lockin_rr_arbiter
    import port_map_pkg::*;
(
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic [NUM_PORTS-1:0] req_i,
    input  logic                 accept_i,
    output logic                 grant_valid_o,
    output port_idx_t            grant_idx_o
);

    logic      frozen_d, frozen_q;
    port_idx_t lock_idx_d, lock_idx_q;
    port_idx_t ptr_d, ptr_q;

    logic      rr_valid;
    port_idx_t rr_idx;

    function automatic port_idx_t wrap_idx(input int value);
        return port_idx_t'(value % NUM_PORTS);
    endfunction

    // ----------------------------------------
    // round-robin search
    // ----------------------------------------
    // scan downward so the nearest request after ptr_q wins
    always_comb begin : rr_search
        rr_valid = 1'b0;
        rr_idx   = ptr_q;
        for (int k = NUM_PORTS - 1; k >= 0; k--) begin
            if (req_i[wrap_idx(int'(ptr_q) + k)]) begin
                rr_valid = 1'b1;
                rr_idx   = wrap_idx(int'(ptr_q) + k);
            end
        end
    end

    // frozen grant overrides the search
    assign grant_valid_o = frozen_q ? req_i[lock_idx_q] : rr_valid;
    assign grant_idx_o   = frozen_q ? lock_idx_q : rr_idx;

    // ----------------------------------------
    // lock-in state
    // ----------------------------------------
    always_comb begin : lock_next
        frozen_d   = frozen_q;
        lock_idx_d = lock_idx_q;
        ptr_d      = ptr_q;

        // freeze on a fresh grant
        if (!frozen_q && rr_valid) begin
            frozen_d   = 1'b1;
            lock_idx_d = rr_idx;
        end
        // accepted on this edge, release and move past the winner
        if (accept_i) begin
            frozen_d = 1'b0;
            ptr_d    = wrap_idx(int'(grant_idx_o) + 1);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            frozen_q   <= 1'b0;
            lock_idx_q <= '0;
            ptr_q      <= '0;
        end else begin
            frozen_q   <= frozen_d;
            lock_idx_q <= lock_idx_d;
            ptr_q      <= ptr_d;
        end
    end

    // requester keeps its request up once granted and not yet accepted
    a_req_held: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (grant_valid_o && !accept_i) |=> req_i[lock_idx_q]
    ) else $error("granted request dropped before acceptance");

endmodule

// ==== logic/resp_router.sv ====
// Steers the shared response channel to one requester by transaction id.
// 0000 goes to icache, 10xx to bypass, 1111 and anything else to dcache.
// Fully combinational, ready comes back from the selected requester only.
module resp_router
    import mem_bus_pkg::*;
    import port_map_pkg::*;
(
    mem_rsp_if.sink   rsp_in,
    mem_rsp_if.source rsp_out [NUM_PORTS]
);

    rsp_id_u                id_view;
    port_idx_t              sel;
    logic [NUM_PORTS-1:0]   valid_vec;
    logic [NUM_PORTS-1:0]   ready_vec;

    assign id_view.raw = rsp_in.payload.id;

    // ----------------------------------------
    // id decode
    // ----------------------------------------
    // exact ids first, then the bypass class
    always_comb begin : id_decode
        if (id_view.raw == ID_ICACHE) begin
            sel = port_idx_t'(PORT_ICACHE);
        end else if (id_view.raw == ID_DCACHE) begin
            sel = port_idx_t'(PORT_DCACHE);
        end else if (id_view.fields.cls == CLS_BYPASS) begin
            sel = port_idx_t'(PORT_BYPASS);
        end else begin
            // unknown ids fall back to dcache
            sel = port_idx_t'(PORT_DCACHE);
        end
    end

    // ----------------------------------------
    // output steering
    // ----------------------------------------
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_out
        // payload goes everywhere, only valid is steered
        assign rsp_out[i].payload = rsp_in.payload;
        assign valid_vec[i]       = rsp_in.valid && (sel == port_idx_t'(i));
        assign rsp_out[i].valid   = valid_vec[i];
        assign ready_vec[i]       = rsp_out[i].ready;
    end

    assign rsp_in.ready = ready_vec[sel];

endmodule

// ==== port_join/req_chan_mux.sv ====
// Joins the requester channels onto one bus request channel.
// A lock-in round-robin arbiter picks the input, the path is combinational.
// Non-granted inputs see ready low and wait.
module req_chan_mux
    import mem_bus_pkg::*;
    import port_map_pkg::*;
(
    input  logic         clk_i,
    input  logic         rst_ni,
    mem_req_if.target    req_in [NUM_PORTS],
    mem_req_if.initiator req_out
);

    logic [NUM_PORTS-1:0] valid_vec;
    mem_req_t             payload_arr [NUM_PORTS];

    logic      grant_valid;
    port_idx_t grant_idx;
    logic      bus_accept;

    // ----------------------------------------
    // input collection and ready return
    // ----------------------------------------
    for (genvar i = 0; i < NUM_PORTS; i++) begin : g_in
        assign valid_vec[i]    = req_in[i].valid;
        assign payload_arr[i]  = req_in[i].payload;
        // only the granted input sees the bus ready
        assign req_in[i].ready = grant_valid && (grant_idx == port_idx_t'(i)) && req_out.ready;
    end

    // ----------------------------------------
    // arbitration
    // ----------------------------------------
    assign bus_accept = grant_valid && req_out.ready;

    lockin_rr_arbiter u_arbiter (
        .clk_i         ( clk_i       ),
        .rst_ni        ( rst_ni      ),
        .req_i         ( valid_vec   ),
        .accept_i      ( bus_accept  ),
        .grant_valid_o ( grant_valid ),
        .grant_idx_o   ( grant_idx   )
    );

    // grant is only valid while the granted input requests
    assign req_out.valid   = grant_valid;
    assign req_out.payload = payload_arr[grant_idx];

    // bus side sees a stable request under back-pressure
    a_payload_stable: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        (req_out.valid && !req_out.ready) |=> (req_out.valid && $stable(req_out.payload))
    ) else $error("bus request changed while stalled");

endmodule

// ==== port_join/port_join.sv ====
// Memory port join for the cache subsystem, with plain ports all round.
// Arbitrates dcache, bypass and icache requests onto one bus and routes
// each bus response back by id.
module port_join
    import mem_bus_pkg::*;
    import port_map_pkg::*;
(
    input  logic              clk_i,
    input  logic              rst_ni,
    // dcache
    input  logic              dc_req_valid_i,
    output logic              dc_req_ready_o,
    input  logic [ADDR_W-1:0] dc_req_addr_i,
    input  logic              dc_req_we_i,
    input  logic [DATA_W-1:0] dc_req_wdata_i,
    input  logic [BE_W-1:0]   dc_req_be_i,
    input  logic [ID_W-1:0]   dc_req_id_i,
    output logic              dc_rsp_valid_o,
    input  logic              dc_rsp_ready_i,
    output logic [DATA_W-1:0] dc_rsp_rdata_o,
    output logic [ID_W-1:0]   dc_rsp_id_o,
    output logic              dc_rsp_err_o,
    // uncached bypass
    input  logic              by_req_valid_i,
    output logic              by_req_ready_o,
    input  logic [ADDR_W-1:0] by_req_addr_i,
    input  logic              by_req_we_i,
    input  logic [DATA_W-1:0] by_req_wdata_i,
    input  logic [BE_W-1:0]   by_req_be_i,
    input  logic [ID_W-1:0]   by_req_id_i,
    output logic              by_rsp_valid_o,
    input  logic              by_rsp_ready_i,
    output logic [DATA_W-1:0] by_rsp_rdata_o,
    output logic [ID_W-1:0]   by_rsp_id_o,
    output logic              by_rsp_err_o,
    // icache
    input  logic              ic_req_valid_i,
    output logic              ic_req_ready_o,
    input  logic [ADDR_W-1:0] ic_req_addr_i,
    input  logic              ic_req_we_i,
    input  logic [DATA_W-1:0] ic_req_wdata_i,
    input  logic [BE_W-1:0]   ic_req_be_i,
    input  logic [ID_W-1:0]   ic_req_id_i,
    output logic              ic_rsp_valid_o,
    input  logic              ic_rsp_ready_i,
    output logic [DATA_W-1:0] ic_rsp_rdata_o,
    output logic [ID_W-1:0]   ic_rsp_id_o,
    output logic              ic_rsp_err_o,
    // memory bus
    output logic              bus_req_valid_o,
    input  logic              bus_req_ready_i,
    output logic [ADDR_W-1:0] bus_req_addr_o,
    output logic              bus_req_we_o,
    output logic [DATA_W-1:0] bus_req_wdata_o,
    output logic [BE_W-1:0]   bus_req_be_o,
    output logic [ID_W-1:0]   bus_req_id_o,
    input  logic              bus_rsp_valid_i,
    output logic              bus_rsp_ready_o,
    input  logic [DATA_W-1:0] bus_rsp_rdata_i,
    input  logic [ID_W-1:0]   bus_rsp_id_i,
    input  logic              bus_rsp_err_i
);

    mem_req_if req_if [NUM_PORTS] ();
    mem_rsp_if rsp_if [NUM_PORTS] ();
    mem_req_if bus_req_if ();
    mem_rsp_if bus_rsp_if ();

    // ----------------------------------------
    // requester side bundling
    // ----------------------------------------
    assign req_if[PORT_DCACHE].valid   = dc_req_valid_i;
    assign req_if[PORT_DCACHE].payload = '{addr: dc_req_addr_i, we: dc_req_we_i,
        wdata: dc_req_wdata_i, be: dc_req_be_i, id: dc_req_id_i};
    assign dc_req_ready_o              = req_if[PORT_DCACHE].ready;
    assign dc_rsp_valid_o              = rsp_if[PORT_DCACHE].valid;
    assign dc_rsp_rdata_o              = rsp_if[PORT_DCACHE].payload.rdata;
    assign dc_rsp_id_o                 = rsp_if[PORT_DCACHE].payload.id;
    assign dc_rsp_err_o                = rsp_if[PORT_DCACHE].payload.err;
    assign rsp_if[PORT_DCACHE].ready   = dc_rsp_ready_i;

    assign req_if[PORT_BYPASS].valid   = by_req_valid_i;
    assign req_if[PORT_BYPASS].payload = '{addr: by_req_addr_i, we: by_req_we_i,
        wdata: by_req_wdata_i, be: by_req_be_i, id: by_req_id_i};
    assign by_req_ready_o              = req_if[PORT_BYPASS].ready;
    assign by_rsp_valid_o              = rsp_if[PORT_BYPASS].valid;
    assign by_rsp_rdata_o              = rsp_if[PORT_BYPASS].payload.rdata;
    assign by_rsp_id_o                 = rsp_if[PORT_BYPASS].payload.id;
    assign by_rsp_err_o                = rsp_if[PORT_BYPASS].payload.err;
    assign rsp_if[PORT_BYPASS].ready   = by_rsp_ready_i;

    assign req_if[PORT_ICACHE].valid   = ic_req_valid_i;
    assign req_if[PORT_ICACHE].payload = '{addr: ic_req_addr_i, we: ic_req_we_i,
        wdata: ic_req_wdata_i, be: ic_req_be_i, id: ic_req_id_i};
    assign ic_req_ready_o              = req_if[PORT_ICACHE].ready;
    assign ic_rsp_valid_o              = rsp_if[PORT_ICACHE].valid;
    assign ic_rsp_rdata_o              = rsp_if[PORT_ICACHE].payload.rdata;
    assign ic_rsp_id_o                 = rsp_if[PORT_ICACHE].payload.id;
    assign ic_rsp_err_o                = rsp_if[PORT_ICACHE].payload.err;
    assign rsp_if[PORT_ICACHE].ready   = ic_rsp_ready_i;

    // ----------------------------------------
    // bus side bundling
    // ----------------------------------------
    assign bus_req_valid_o    = bus_req_if.valid;
    assign bus_req_addr_o     = bus_req_if.payload.addr;
    assign bus_req_we_o       = bus_req_if.payload.we;
    assign bus_req_wdata_o    = bus_req_if.payload.wdata;
    assign bus_req_be_o       = bus_req_if.payload.be;
    assign bus_req_id_o       = bus_req_if.payload.id;
    assign bus_req_if.ready   = bus_req_ready_i;

    assign bus_rsp_if.valid   = bus_rsp_valid_i;
    assign bus_rsp_if.payload = '{rdata: bus_rsp_rdata_i, id: bus_rsp_id_i, err: bus_rsp_err_i};
    assign bus_rsp_ready_o    = bus_rsp_if.ready;

    // request arbitration and response routing
    req_chan_mux u_req_mux (
        .clk_i   ( clk_i      ),
        .rst_ni  ( rst_ni     ),
        .req_in  ( req_if     ),
        .req_out ( bus_req_if )
    );

    resp_router u_rsp_router (
        .rsp_in  ( bus_rsp_if ),
        .rsp_out ( rsp_if     )
    );

endmodule

// ==== sim/tb_port_join.sv ====
// Directed testbench for the memory port join.
// Plays the three requesters and the memory bus, checks arbitration order,
// lock-in under back-pressure and response routing by id.
module tb_port_join
    import mem_bus_pkg::*;
    import port_map_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD   = 20;
    localparam int WAIT_LIMIT   = 16;
    localparam int RESET_CYCLES = 3;
    // three resets, worst-case waits of the request tests, fixed response cycles
    localparam int TEST_CYCLES  = 3 * RESET_CYCLES + 7 * WAIT_LIMIT + 30;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 50) * CLK_PERIOD;

    logic clk_i;
    logic rst_ni;

    // requester side, indexed by the port numbering
    logic [NUM_PORTS-1:0]             req_valid;
    wire  [NUM_PORTS-1:0]             req_ready;
    logic [NUM_PORTS-1:0][ADDR_W-1:0] req_addr;
    logic [NUM_PORTS-1:0]             req_we;
    logic [NUM_PORTS-1:0][DATA_W-1:0] req_wdata;
    logic [NUM_PORTS-1:0][BE_W-1:0]   req_be;
    logic [NUM_PORTS-1:0][ID_W-1:0]   req_id;
    wire  [NUM_PORTS-1:0]             rsp_valid;
    logic [NUM_PORTS-1:0]             rsp_ready;
    wire  [NUM_PORTS-1:0][DATA_W-1:0] rsp_rdata;
    wire  [NUM_PORTS-1:0][ID_W-1:0]   rsp_id;
    wire  [NUM_PORTS-1:0]             rsp_err;

    // memory bus side
    logic              bus_req_ready_i;
    logic              bus_req_valid_o;
    logic [ADDR_W-1:0] bus_req_addr_o;
    logic              bus_req_we_o;
    logic [DATA_W-1:0] bus_req_wdata_o;
    logic [BE_W-1:0]   bus_req_be_o;
    logic [ID_W-1:0]   bus_req_id_o;
    logic              bus_rsp_valid_i;
    logic              bus_rsp_ready_o;
    logic [DATA_W-1:0] bus_rsp_rdata_i;
    logic [ID_W-1:0]   bus_rsp_id_i;
    logic              bus_rsp_err_i;

    port_join u_port_join (
        .clk_i           ( clk_i                   ),
        .rst_ni          ( rst_ni                  ),
        .dc_req_valid_i  ( req_valid[PORT_DCACHE]  ),
        .dc_req_ready_o  ( req_ready[PORT_DCACHE]  ),
        .dc_req_addr_i   ( req_addr[PORT_DCACHE]   ),
        .dc_req_we_i     ( req_we[PORT_DCACHE]     ),
        .dc_req_wdata_i  ( req_wdata[PORT_DCACHE]  ),
        .dc_req_be_i     ( req_be[PORT_DCACHE]     ),
        .dc_req_id_i     ( req_id[PORT_DCACHE]     ),
        .dc_rsp_valid_o  ( rsp_valid[PORT_DCACHE]  ),
        .dc_rsp_ready_i  ( rsp_ready[PORT_DCACHE]  ),
        .dc_rsp_rdata_o  ( rsp_rdata[PORT_DCACHE]  ),
        .dc_rsp_id_o     ( rsp_id[PORT_DCACHE]     ),
        .dc_rsp_err_o    ( rsp_err[PORT_DCACHE]    ),
        .by_req_valid_i  ( req_valid[PORT_BYPASS]  ),
        .by_req_ready_o  ( req_ready[PORT_BYPASS]  ),
        .by_req_addr_i   ( req_addr[PORT_BYPASS]   ),
        .by_req_we_i     ( req_we[PORT_BYPASS]     ),
        .by_req_wdata_i  ( req_wdata[PORT_BYPASS]  ),
        .by_req_be_i     ( req_be[PORT_BYPASS]     ),
        .by_req_id_i     ( req_id[PORT_BYPASS]     ),
        .by_rsp_valid_o  ( rsp_valid[PORT_BYPASS]  ),
        .by_rsp_ready_i  ( rsp_ready[PORT_BYPASS]  ),
        .by_rsp_rdata_o  ( rsp_rdata[PORT_BYPASS]  ),
        .by_rsp_id_o     ( rsp_id[PORT_BYPASS]     ),
        .by_rsp_err_o    ( rsp_err[PORT_BYPASS]    ),
        .ic_req_valid_i  ( req_valid[PORT_ICACHE]  ),
        .ic_req_ready_o  ( req_ready[PORT_ICACHE]  ),
        .ic_req_addr_i   ( req_addr[PORT_ICACHE]   ),
        .ic_req_we_i     ( req_we[PORT_ICACHE]     ),
        .ic_req_wdata_i  ( req_wdata[PORT_ICACHE]  ),
        .ic_req_be_i     ( req_be[PORT_ICACHE]     ),
        .ic_req_id_i     ( req_id[PORT_ICACHE]     ),
        .ic_rsp_valid_o  ( rsp_valid[PORT_ICACHE]  ),
        .ic_rsp_ready_i  ( rsp_ready[PORT_ICACHE]  ),
        .ic_rsp_rdata_o  ( rsp_rdata[PORT_ICACHE]  ),
        .ic_rsp_id_o     ( rsp_id[PORT_ICACHE]     ),
        .ic_rsp_err_o    ( rsp_err[PORT_ICACHE]    ),
        .bus_req_valid_o ( bus_req_valid_o         ),
        .bus_req_ready_i ( bus_req_ready_i         ),
        .bus_req_addr_o  ( bus_req_addr_o          ),
        .bus_req_we_o    ( bus_req_we_o            ),
        .bus_req_wdata_o ( bus_req_wdata_o         ),
        .bus_req_be_o    ( bus_req_be_o            ),
        .bus_req_id_o    ( bus_req_id_o            ),
        .bus_rsp_valid_i ( bus_rsp_valid_i         ),
        .bus_rsp_ready_o ( bus_rsp_ready_o         ),
        .bus_rsp_rdata_i ( bus_rsp_rdata_i         ),
        .bus_rsp_id_i    ( bus_rsp_id_i            ),
        .bus_rsp_err_i   ( bus_rsp_err_i           )
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    task automatic fail_check(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("test failed");
        $fatal(1, "stopped at first error");
    endtask

    // request ids per requester, matching their response classes
    function automatic logic [ID_W-1:0] requester_id(input int p);
        case (p)
            PORT_DCACHE: return 4'b1111;
            PORT_BYPASS: return 4'b1001;
            default:     return 4'b0000;
        endcase
    endfunction

    task automatic idle_inputs();
        req_valid       = '0;
        req_addr        = '0;
        req_we          = '0;
        req_wdata       = '0;
        req_be          = '0;
        req_id          = '0;
        rsp_ready       = '1;
        bus_req_ready_i = 1'b0;
        bus_rsp_valid_i = 1'b0;
        bus_rsp_rdata_i = '0;
        bus_rsp_id_i    = '0;
        bus_rsp_err_i   = 1'b0;
    endtask

    task automatic apply_reset();
        @(negedge clk_i);
        idle_inputs();
        rst_ni = 1'b0;
        repeat (2) @(negedge clk_i);
        rst_ni = 1'b1;
    endtask

    // fresh random payload, requester keeps its id
    task automatic present_request(input int p);
        req_addr[p]  = $urandom;
        req_we[p]    = $urandom % 2;
        req_wdata[p] = {$urandom, $urandom};
        req_be[p]    = $urandom;
        req_id[p]    = requester_id(p);
        req_valid[p] = 1'b1;
    endtask

    task automatic check_bus_payload(input int p);
        assert (bus_req_valid_o) else fail_check("bus request valid is low");
        assert (bus_req_addr_o == req_addr[p] && bus_req_we_o == req_we[p]
                && bus_req_wdata_o == req_wdata[p] && bus_req_be_o == req_be[p]
                && bus_req_id_o == req_id[p])
            else fail_check($sformatf("bus payload id %b is not from requester %0d",
                bus_req_id_o, p));
    endtask

    // called just after a falling edge, returns once a transfer is pending
    task automatic wait_bus_accept(output logic [ID_W-1:0] id);
        int cycles;
        cycles = 0;
        while (!(bus_req_valid_o && bus_req_ready_i)) begin
            cycles++;
            assert (cycles < WAIT_LIMIT) else fail_check("bus request never accepted");
            @(negedge clk_i);
            #1;
        end
        id = bus_req_id_o;
    endtask

    task automatic drive_response(input logic [ID_W-1:0] id);
        bus_rsp_valid_i = 1'b1;
        bus_rsp_rdata_i = {$urandom, $urandom};
        bus_rsp_id_i    = id;
        bus_rsp_err_i   = $urandom % 2;
    endtask

    task automatic check_routed(input int exp_port);
        for (int p = 0; p < NUM_PORTS; p++) begin
            assert (rsp_valid[p] == (p == exp_port))
                else fail_check($sformatf("id %b gives valid %b on requester %0d",
                    bus_rsp_id_i, rsp_valid[p], p));
        end
        assert (rsp_rdata[exp_port] == bus_rsp_rdata_i && rsp_id[exp_port] == bus_rsp_id_i
                && rsp_err[exp_port] == bus_rsp_err_i)
            else fail_check($sformatf("response payload wrong at requester %0d", exp_port));
    endtask

    // ----------------------------------------
    // tests
    // ----------------------------------------
    task automatic test_pass_through();
        apply_reset();
        @(negedge clk_i);
        present_request(PORT_BYPASS);
        bus_req_ready_i = 1'b1;
        #1;
        check_bus_payload(PORT_BYPASS);
        assert (req_ready[PORT_BYPASS]) else fail_check("bypass ready low on a free bus");
        @(negedge clk_i);
        req_valid[PORT_BYPASS] = 1'b0;
    endtask

    task automatic test_round_robin();
        logic [ID_W-1:0] id;
        int              exp_port;
        apply_reset();
        @(negedge clk_i);
        bus_req_ready_i = 1'b1;
        for (int p = 0; p < NUM_PORTS; p++) begin
            present_request(p);
        end
        #1;
        for (int n = 0; n < 4; n++) begin
            exp_port = n % NUM_PORTS;
            wait_bus_accept(id);
            assert (id == requester_id(exp_port))
                else fail_check($sformatf("grant %0d went to id %b", n, id));
            check_bus_payload(exp_port);
            assert (req_ready[exp_port]) else fail_check("granted requester sees ready low");
            @(negedge clk_i);
            present_request(exp_port);
            #1;
        end
        req_valid = '0;
    endtask

    task automatic test_lock_in();
        logic [ID_W-1:0] id;
        apply_reset();
        // one bypass transfer puts icache ahead of dcache in the search
        @(negedge clk_i);
        present_request(PORT_BYPASS);
        bus_req_ready_i = 1'b1;
        #1;
        wait_bus_accept(id);
        assert (id == requester_id(PORT_BYPASS)) else fail_check("bypass not accepted");
        @(negedge clk_i);
        req_valid[PORT_BYPASS] = 1'b0;
        bus_req_ready_i        = 1'b0;
        present_request(PORT_DCACHE);
        #1;
        check_bus_payload(PORT_DCACHE);
        // bus stalls for five cycles in all
        for (int c = 0; c < 4; c++) begin
            @(negedge clk_i);
            if (c == 0) begin
                present_request(PORT_ICACHE);
            end
            #1;
            check_bus_payload(PORT_DCACHE);
            assert (!req_ready[PORT_ICACHE]) else fail_check("icache ready high while locked");
        end
        @(negedge clk_i);
        bus_req_ready_i = 1'b1;
        #1;
        wait_bus_accept(id);
        assert (id == requester_id(PORT_DCACHE)) else fail_check("dcache not accepted first");
        assert (!req_ready[PORT_ICACHE]) else fail_check("icache ready with dcache on bus");
        @(negedge clk_i);
        req_valid[PORT_DCACHE] = 1'b0;
        #1;
        wait_bus_accept(id);
        assert (id == requester_id(PORT_ICACHE)) else fail_check("icache not accepted next");
        check_bus_payload(PORT_ICACHE);
        @(negedge clk_i);
        req_valid[PORT_ICACHE] = 1'b0;
    endtask

    task automatic test_response_routing();
        logic [ID_W-1:0] ids [5] = '{4'b0000, 4'b1000, 4'b1011, 4'b1111, 4'b0101};
        int              dests [5] = '{PORT_ICACHE, PORT_BYPASS, PORT_BYPASS,
                                       PORT_DCACHE, PORT_DCACHE};
        rsp_ready = '1;
        for (int k = 0; k < 5; k++) begin
            @(negedge clk_i);
            drive_response(ids[k]);
            #1;
            check_routed(dests[k]);
            assert (bus_rsp_ready_o) else fail_check("bus response ready low");
        end
        @(negedge clk_i);
        bus_rsp_valid_i = 1'b0;
    endtask

    task automatic test_response_stall();
        @(negedge clk_i);
        rsp_ready = '1;
        rsp_ready[PORT_ICACHE] = 1'b0;
        drive_response(4'b1111);
        #1;
        check_routed(PORT_DCACHE);
        assert (bus_rsp_ready_o) else fail_check("dcache response stalled by icache");
        @(negedge clk_i);
        drive_response(4'b0000);
        // icache back-pressure holds the bus response
        for (int c = 0; c < 3; c++) begin
            #1;
            check_routed(PORT_ICACHE);
            assert (!bus_rsp_ready_o) else fail_check("bus ready high with icache stalled");
            @(negedge clk_i);
        end
        rsp_ready[PORT_ICACHE] = 1'b1;
        #1;
        assert (bus_rsp_ready_o) else fail_check("bus ready low after icache ready");
        @(negedge clk_i);
        bus_rsp_valid_i = 1'b0;
    endtask

    // ----------------------------------------
    // main sequence and watchdog
    // ----------------------------------------
    initial begin
        void'($urandom(32'hc4f981bf));
        rst_ni = 1'b0;
        idle_inputs();
        test_pass_through();
        test_round_robin();
        test_lock_in();
        test_response_routing();
        test_response_stall();
        $display("test passed");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out at %0t before the tests finished", $time);
        $display("test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// ==== port_join.f ====
common/mem_bus_pkg.sv
common/port_map_pkg.sv
common/mem_req_if.sv
common/mem_rsp_if.sv
logic/lockin_rr_arbiter.sv
logic/resp_router.sv
port_join/req_chan_mux.sv
port_join/port_join.sv
sim/tb_port_join.sv
